/* hdl/cpu_ctl_pkg.sv */
package cpu_ctl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Instruction bytes arrive one per cycle, up to four per instruction
    localparam int BYTE_W    = 8;
    localparam int INSN_W    = 32;
    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 4;
    localparam int OPCODE_W  = 4;
    localparam int ALU_OP_W  = 3;
    localparam int CTL_W     = 11;
    localparam int STEP_W    = 5;

    // Register file size and the number of operand buses
    localparam int NUM_REGS  = 16;
    localparam int NUM_BUSES = 3;

    typedef logic [BYTE_W-1:0]              byte_t;
    typedef logic [INSN_W-1:0]              insn_t;
    typedef logic [WORD_W-1:0]              word_t;
    typedef logic [REG_IDX_W-1:0]           reg_idx_t;
    typedef logic [NUM_REGS-1:0]            reg_mask_t;
    // Bit reg*3+bus puts a register onto bus A, B or C
    typedef logic [NUM_REGS*NUM_BUSES-1:0]  bus_mask_t;
    typedef logic [ALU_OP_W-1:0]            alu_op_t;
    typedef logic [CTL_W-1:0]               ctl_word_t;

    // Bus numbers inside one register's group of three enables
    localparam int unsigned BUS_A = 0;
    localparam int unsigned BUS_B = 1;
    localparam int unsigned BUS_C = 2;

    // Register 0 holds the program counter
    localparam reg_idx_t REG_PC = 4'd0;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int FIELD_OP_LSB  = 4;
    localparam int FIELD_A_LSB   = 0;
    localparam int FIELD_C_LSB   = 8;
    localparam int FIELD_B_LSB   = 12;
    localparam int IMM_SHORT_LSB = 8;
    localparam int IMM_LONG_LSB  = 16;

    // ALU operation codes
    localparam alu_op_t ALU_ADD    = 3'b000;
    localparam alu_op_t ALU_ADD_HI = 3'b001;
    localparam alu_op_t ALU_SUB    = 3'b010;
    localparam alu_op_t ALU_ROT    = 3'b011;
    localparam alu_op_t ALU_LOGIC  = 3'b100;
    localparam alu_op_t ALU_BEZ    = 3'b101;
    localparam alu_op_t ALU_BNEZ   = 3'b110;
    localparam alu_op_t ALU_BGEZ   = 3'b111;

    // Datapath steering words, same bit values as the existing datapath expects
    localparam ctl_word_t CTL_FETCH      = 11'b00010010101;
    localparam ctl_word_t CTL_REG_REG    = 11'b00010000011;
    localparam ctl_word_t CTL_REG_IMM    = 11'b00010000101;
    localparam ctl_word_t CTL_IMM_TO_REG = 11'b00101000000;
    localparam ctl_word_t CTL_STORE_LO   = 11'b01000100101;
    localparam ctl_word_t CTL_STORE_HI   = 11'b10000100101;

    typedef enum logic [OPCODE_W-1:0] {
        OP_PUSH_R  = 4'b0000,
        OP_POP     = 4'b0001,
        OP_LFUN_RR = 4'b0010,
        OP_ADD_RR  = 4'b0011,
        OP_SUB_RR  = 4'b0100,
        OP_ROT_RR  = 4'b0101,
        OP_ROT_RC  = 4'b0110,
        OP_ADD_RC  = 4'b0111,
        OP_MOV_RC  = 4'b1000,
        OP_PUSH_C  = 4'b1001,
        OP_LFUN_RC = 4'b1010,
        OP_BEZ     = 4'b1011,
        OP_BNEZ    = 4'b1100,
        OP_BGEZ    = 4'b1101,
        OP_LOAD    = 4'b1110,
        OP_STORE   = 4'b1111
    } opcode_t;

    typedef enum logic [STEP_W-1:0] {
        ST_FETCH    = 5'd0,
        ST_DECODE   = 5'd1,
        ST_EXEC     = 5'd2,
        ST_STORE_LO = 5'd3,
        ST_STORE_HI = 5'd4
    } step_t;

endpackage

/* hdl/insn_fetch.sv */
`timescale 1ns/1ps

module insn_fetch (
    input  logic               clk,
    input  logic               reset,
    input  cpu_ctl_pkg::byte_t data_in,
    input  logic               fetch_en,
    output cpu_ctl_pkg::insn_t insn,
    output logic               insn_done
);

    import cpu_ctl_pkg::*;

    // Index of the byte being captured, 0 to 3
    logic [1:0] byte_cnt;
    // Index of the last byte of the current instruction
    logic [1:0] last_idx;
    opcode_t    cur_op;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode length table
    ////////////////////////////////////////////////////////////////////////////

    // Returns the instruction length minus one
    function automatic logic [1:0] last_byte(input opcode_t op);
        case (op)
            OP_PUSH_R, OP_POP:
                last_byte = 2'd0;
            OP_LFUN_RR, OP_ADD_RR, OP_SUB_RR, OP_ROT_RR, OP_ROT_RC:
                last_byte = 2'd1;
            OP_ADD_RC, OP_MOV_RC, OP_PUSH_C:
                last_byte = 2'd2;
            default:
                last_byte = 2'd3;
        endcase
    endfunction

    // On byte 0 the opcode is still on the input and not yet in the register
    assign cur_op = (byte_cnt == 2'd0) ? opcode_t'(data_in[FIELD_OP_LSB +: OPCODE_W])
                                       : opcode_t'(insn[FIELD_OP_LSB +: OPCODE_W]);

    assign last_idx = last_byte(cur_op);

    // High in the cycle whose rising edge captures the final byte
    assign insn_done = fetch_en && (byte_cnt == last_idx);

    ////////////////////////////////////////////////////////////////////////////
    // Byte lanes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            insn     <= '0;
            byte_cnt <= 2'd0;
        end else if (fetch_en) begin
            // Byte n lands in bits 8n+7 down to 8n
            insn[byte_cnt * BYTE_W +: BYTE_W] <= data_in;
            // The count restarts so the next fetch begins at byte 0
            if (insn_done) begin
                byte_cnt <= 2'd0;
            end else begin
                byte_cnt <= byte_cnt + 2'd1;
            end
        end
    end

endmodule

/* hdl/exec_sequencer.sv */
`timescale 1ns/1ps

module exec_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 insn_done,
    input  cpu_ctl_pkg::opcode_t opcode,
    output cpu_ctl_pkg::step_t   step,
    output logic                 fetch_en
);

    import cpu_ctl_pkg::*;

    step_t next_step;

    ////////////////////////////////////////////////////////////////////////////
    // Next step
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_step = step;
        case (step)
            ST_FETCH: begin
                // Stay here until the last byte of the instruction is taken
                if (insn_done) begin
                    next_step = ST_DECODE;
                end
            end
            ST_DECODE: begin
                // The instruction register is complete by now, so the
                // execute path is chosen from the registered opcode
                case (opcode)
                    // Stack and load instructions are not supported and
                    // fall straight through to the next fetch
                    OP_PUSH_R, OP_POP, OP_PUSH_C, OP_LOAD: begin
                        next_step = ST_FETCH;
                    end
                    OP_STORE: begin
                        next_step = ST_STORE_LO;
                    end
                    default: begin
                        next_step = ST_EXEC;
                    end
                endcase
            end
            ST_EXEC: begin
                next_step = ST_FETCH;
            end
            // Store writes the low byte, then the high byte
            ST_STORE_LO: begin
                next_step = ST_STORE_HI;
            end
            ST_STORE_HI: begin
                next_step = ST_FETCH;
            end
            default: begin
                next_step = ST_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= ST_FETCH;
        end else begin
            step <= next_step;
        end
    end

    // Bytes are only accepted while fetching
    assign fetch_en = (step == ST_FETCH);

endmodule

/* hdl/ctl_word_gen.sv */
`timescale 1ns/1ps

module ctl_word_gen (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_ctl_pkg::step_t     step,
    input  cpu_ctl_pkg::insn_t     insn,
    output logic                   data_write_en,
    output cpu_ctl_pkg::alu_op_t   alu_op,
    output cpu_ctl_pkg::reg_idx_t  alu_logic_func,
    output cpu_ctl_pkg::ctl_word_t ctl_out,
    output cpu_ctl_pkg::word_t     immediate,
    output cpu_ctl_pkg::reg_mask_t write_en,
    output cpu_ctl_pkg::bus_mask_t output_en
);

    import cpu_ctl_pkg::*;

    opcode_t   opcode;
    reg_idx_t  field_a;
    reg_idx_t  field_b;
    reg_idx_t  field_c;
    word_t     imm_short;
    word_t     imm_long;

    // One-hot selects built from the register fields
    reg_mask_t wr_a;
    reg_mask_t wr_b;
    bus_mask_t a_on_a;
    bus_mask_t b_on_a;
    bus_mask_t b_on_b;
    bus_mask_t b_on_c;
    bus_mask_t c_on_a;
    bus_mask_t c_on_b;

    ////////////////////////////////////////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////////////////////////////////////////

    function automatic reg_mask_t reg_sel(input reg_idx_t idx);
        reg_sel = reg_mask_t'(1) << idx;
    endfunction

    // Each register owns three adjacent enables, one per bus
    function automatic bus_mask_t bus_sel(input reg_idx_t idx, input int unsigned bus);
        bus_sel = bus_mask_t'(1) << (idx * NUM_BUSES + bus);
    endfunction

    // ALU code for every opcode that has an execute step
    function automatic alu_op_t alu_code(input opcode_t op);
        case (op)
            OP_LFUN_RR, OP_LFUN_RC: alu_code = ALU_LOGIC;
            OP_SUB_RR:              alu_code = ALU_SUB;
            OP_ROT_RR, OP_ROT_RC:   alu_code = ALU_ROT;
            OP_BEZ:                 alu_code = ALU_BEZ;
            OP_BNEZ:                alu_code = ALU_BNEZ;
            OP_BGEZ:                alu_code = ALU_BGEZ;
            default:                alu_code = ALU_ADD;
        endcase
    endfunction

    assign opcode    = opcode_t'(insn[FIELD_OP_LSB +: OPCODE_W]);
    assign field_a   = insn[FIELD_A_LSB +: REG_IDX_W];
    assign field_b   = insn[FIELD_B_LSB +: REG_IDX_W];
    assign field_c   = insn[FIELD_C_LSB +: REG_IDX_W];
    assign imm_short = insn[IMM_SHORT_LSB +: WORD_W];
    assign imm_long  = insn[IMM_LONG_LSB +: WORD_W];

    // The logic function select goes to the ALU straight from field c
    assign alu_logic_func = field_c;

    assign wr_a   = reg_sel(field_a);
    assign wr_b   = reg_sel(field_b);
    assign a_on_a = bus_sel(field_a, BUS_A);
    assign b_on_a = bus_sel(field_b, BUS_A);
    assign b_on_b = bus_sel(field_b, BUS_B);
    assign b_on_c = bus_sel(field_b, BUS_C);
    assign c_on_a = bus_sel(field_c, BUS_A);
    assign c_on_b = bus_sel(field_c, BUS_B);

    ////////////////////////////////////////////////////////////////////////////
    // Registered outputs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_write_en <= 1'b0;
            alu_op        <= '0;
            ctl_out       <= '0;
            immediate     <= '0;
            write_en      <= '0;
            output_en     <= '0;
        end else begin
            // Memory writes happen in the two store steps only
            data_write_en <= 1'b0;
            case (step)
                ST_FETCH: begin
                    // PC goes out on bus A as the address and comes back plus one
                    write_en  <= reg_sel(REG_PC);
                    output_en <= bus_sel(REG_PC, BUS_A);
                    alu_op    <= ALU_ADD;
                    ctl_out   <= CTL_FETCH;
                    immediate <= word_t'(1);
                end
                ST_DECODE: begin
                    // Nothing is written while the opcode is decoded
                    write_en <= '0;
                end
                ST_EXEC: begin
                    case (opcode)
                        OP_LFUN_RR: begin
                            write_en  <= wr_a;
                            output_en <= a_on_a | b_on_b;
                            alu_op    <= alu_code(opcode);
                            ctl_out   <= CTL_REG_REG;
                        end
                        OP_ADD_RR, OP_SUB_RR, OP_ROT_RR: begin
                            write_en  <= wr_b;
                            output_en <= b_on_a | c_on_b;
                            alu_op    <= alu_code(opcode);
                            ctl_out   <= CTL_REG_REG;
                        end
                        OP_ROT_RC, OP_ADD_RC: begin
                            write_en  <= wr_a;
                            output_en <= a_on_a;
                            alu_op    <= alu_code(opcode);
                            ctl_out   <= CTL_REG_IMM;
                            // Rotate takes its small count from field c
                            immediate <= (opcode == OP_ROT_RC) ? word_t'(field_c) : imm_short;
                        end
                        OP_MOV_RC: begin
                            // Immediate goes straight into the register, the ALU is idle
                            write_en  <= wr_a;
                            output_en <= '0;
                            ctl_out   <= CTL_IMM_TO_REG;
                            immediate <= imm_short;
                        end
                        OP_LFUN_RC: begin
                            write_en  <= wr_b;
                            output_en <= b_on_a;
                            alu_op    <= alu_code(opcode);
                            ctl_out   <= CTL_REG_IMM;
                            immediate <= imm_long;
                        end
                        OP_BEZ, OP_BNEZ, OP_BGEZ: begin
                            // Target base on bus A, tested register on bus C
                            write_en  <= reg_sel(REG_PC);
                            output_en <= c_on_a | b_on_c;
                            alu_op    <= alu_code(opcode);
                            ctl_out   <= CTL_REG_IMM;
                            immediate <= imm_long;
                        end
                        default: begin
                            write_en <= '0;
                        end
                    endcase
                end
                ST_STORE_LO, ST_STORE_HI: begin
                    // Address is base plus offset, data register rides on bus B
                    write_en      <= '0;
                    data_write_en <= 1'b1;
                    output_en     <= b_on_a | c_on_b;
                    immediate     <= imm_long;
                    alu_op        <= (step == ST_STORE_LO) ? ALU_ADD : ALU_ADD_HI;
                    ctl_out       <= (step == ST_STORE_LO) ? CTL_STORE_LO : CTL_STORE_HI;
                end
                default: begin
                    write_en <= '0;
                end
            endcase
        end
    end

endmodule

/* hdl/cpu_ctl_top.sv */
`timescale 1ns/1ps

module cpu_ctl_top (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_ctl_pkg::byte_t     data_in,
    output logic                   data_write_en,
    output cpu_ctl_pkg::alu_op_t   alu_op,
    output cpu_ctl_pkg::reg_idx_t  alu_logic_func,
    output cpu_ctl_pkg::ctl_word_t ctl_out,
    output cpu_ctl_pkg::word_t     immediate,
    output cpu_ctl_pkg::reg_mask_t write_en,
    output cpu_ctl_pkg::bus_mask_t output_en
);

    import cpu_ctl_pkg::*;

    // Assembled instruction shared by the sequencer and the output stage
    insn_t   insn;
    logic    insn_done;
    logic    fetch_en;
    step_t   step;
    opcode_t opcode;

    // The sequencer only looks at the opcode nibble of byte 0
    assign opcode = opcode_t'(insn[FIELD_OP_LSB +: OPCODE_W]);

    insn_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .data_in   (data_in),
        .fetch_en  (fetch_en),
        .insn      (insn),
        .insn_done (insn_done)
    );

    exec_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .insn_done (insn_done),
        .opcode    (opcode),
        .step      (step),
        .fetch_en  (fetch_en)
    );

    // Outputs lag the sequencer step by one clock
    ctl_word_gen u_ctl (
        .clk            (clk),
        .reset          (reset),
        .step           (step),
        .insn           (insn),
        .data_write_en  (data_write_en),
        .alu_op         (alu_op),
        .alu_logic_func (alu_logic_func),
        .ctl_out        (ctl_out),
        .immediate      (immediate),
        .write_en       (write_en),
        .output_en      (output_en)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 10 ns period with the first rising edge at 5 ns
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset spans two rising edges and drops on the falling edge after them
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* bench/cpu_ctl_chk.sv */
`timescale 1ns/1ps

module cpu_ctl_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   data_write_en,
    input cpu_ctl_pkg::alu_op_t   alu_op,
    input cpu_ctl_pkg::reg_idx_t  alu_logic_func,
    input cpu_ctl_pkg::ctl_word_t ctl_out,
    input cpu_ctl_pkg::word_t     immediate,
    input cpu_ctl_pkg::reg_mask_t write_en,
    input cpu_ctl_pkg::bus_mask_t output_en
);

    import cpu_ctl_pkg::*;

    // Number of failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // Gathers the enables of one bus across all sixteen registers
    function automatic reg_mask_t bus_column(input bus_mask_t oe, input int unsigned bus);
        reg_mask_t col;
        for (int r = 0; r < NUM_REGS; r++) begin
            col[r] = oe[r * NUM_BUSES + bus];
        end
        return col;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Port properties
    ////////////////////////////////////////////////////////////////////////////

    // Every control output sits at zero while reset is held
    reset_clears: assert property (@(posedge clk) reset |-> (data_write_en == 1'b0 &&
        alu_op == '0 && alu_logic_func == '0 && ctl_out == '0 && immediate == '0 &&
        write_en == '0 && output_en == '0))
        else begin
            $error("control outputs not cleared during reset");
            fail_count++;
        end

    // At most one register is written per cycle
    single_write: assert property (@(posedge clk) $onehot0(write_en))
        else begin
            $error("more than one register write enable set");
            fail_count++;
        end

    // A store holds the memory write for at least two cycles
    store_min_len: assert property (@(posedge clk) disable iff (reset)
        $rose(data_write_en) |=> data_write_en)
        else begin
            $error("memory write lasted a single cycle");
            fail_count++;
        end

    // and never for a third
    store_max_len: assert property (@(posedge clk) disable iff (reset)
        (data_write_en && $past(data_write_en)) |=> !data_write_en)
        else begin
            $error("memory write lasted more than two cycles");
            fail_count++;
        end

    // No bus is driven by two registers at once
    bus_single_driver: assert property (@(posedge clk)
        $onehot0(bus_column(output_en, BUS_A)) && $onehot0(bus_column(output_en, BUS_B)) &&
        $onehot0(bus_column(output_en, BUS_C)))
        else begin
            $error("two registers enabled onto the same bus");
            fail_count++;
        end

endmodule

/* bench/cpu_ctl_tb.sv */
`timescale 1ns/1ps

module cpu_ctl_tb;

    import cpu_ctl_pkg::*;

    // Three passes over all sixteen opcodes
    localparam int NUM_INSNS   = 48;
    // Longest instruction is four fetch, one decode and two store cycles
    localparam int WATCHDOG_NS = NUM_INSNS * 7 * 10 + 200;

    logic      clk;
    logic      reset;
    byte_t     data_in;
    logic      data_write_en;
    alu_op_t   alu_op;
    reg_idx_t  alu_logic_func;
    ctl_word_t ctl_out;
    word_t     immediate;
    reg_mask_t write_en;
    bus_mask_t output_en;

    // Expected outputs, held across steps the way the output registers hold
    logic      exp_dwe;
    alu_op_t   exp_alu;
    ctl_word_t exp_ctl;
    word_t     exp_imm;
    reg_mask_t exp_we;
    bus_mask_t exp_oe;
    reg_idx_t  exp_func;

    integer    seed;
    int        checks;
    int        errors;

    tb_clock u_clock (.clk(clk), .reset(reset));

    cpu_ctl_top dut (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .data_write_en  (data_write_en),
        .alu_op         (alu_op),
        .alu_logic_func (alu_logic_func),
        .ctl_out        (ctl_out),
        .immediate      (immediate),
        .write_en       (write_en),
        .output_en      (output_en)
    );

    bind cpu_ctl_top cpu_ctl_chk chk (
        .clk            (clk),
        .reset          (reset),
        .data_write_en  (data_write_en),
        .alu_op         (alu_op),
        .alu_logic_func (alu_logic_func),
        .ctl_out        (ctl_out),
        .immediate      (immediate),
        .write_en       (write_en),
        .output_en      (output_en)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference timing and output rules
    ////////////////////////////////////////////////////////////////////////////

    // Byte count from the opcode length table
    function automatic int fetch_len(input opcode_t op);
        logic [3:0] v;
        v = op;
        if (v < 4'd2) return 1;
        if (v < 4'd7) return 2;
        if (v < 4'd10) return 3;
        return 4;
    endfunction

    // Stack and load opcodes have no execute step, store has two
    function automatic int exec_len(input opcode_t op);
        if (op == OP_STORE) return 2;
        if (op == OP_PUSH_R || op == OP_POP || op == OP_PUSH_C || op == OP_LOAD) return 0;
        return 1;
    endfunction

    function automatic bus_mask_t bus_bit(input reg_idx_t idx, input int unsigned bus);
        return bus_mask_t'(1) << (int'(idx) * 3 + bus);
    endfunction

    // Sets the expected outputs of execute step number part
    task automatic expect_exec(input logic [31:0] w, input int part);
        reg_idx_t a;
        reg_idx_t b;
        reg_idx_t c;
        a        = w[3:0];
        c        = w[11:8];
        b        = w[15:12];
        exp_dwe  = 1'b0;
        exp_func = c;
        case (opcode_t'(w[7:4]))
            OP_LFUN_RR: begin
                exp_we  = reg_mask_t'(1) << a;
                exp_oe  = bus_bit(a, BUS_A) | bus_bit(b, BUS_B);
                exp_alu = ALU_LOGIC;
                exp_ctl = CTL_REG_REG;
            end
            OP_ADD_RR, OP_SUB_RR, OP_ROT_RR: begin
                exp_we  = reg_mask_t'(1) << b;
                exp_oe  = bus_bit(b, BUS_A) | bus_bit(c, BUS_B);
                exp_alu = (w[7:4] == 4'd3) ? ALU_ADD : (w[7:4] == 4'd4) ? ALU_SUB : ALU_ROT;
                exp_ctl = CTL_REG_REG;
            end
            OP_ROT_RC, OP_ADD_RC: begin
                exp_we  = reg_mask_t'(1) << a;
                exp_oe  = bus_bit(a, BUS_A);
                exp_alu = (w[7:4] == 4'd6) ? ALU_ROT : ALU_ADD;
                exp_ctl = CTL_REG_IMM;
                exp_imm = (w[7:4] == 4'd6) ? {12'b0, c} : w[23:8];
            end
            OP_MOV_RC: begin
                // ALU code keeps its previous value
                exp_we  = reg_mask_t'(1) << a;
                exp_oe  = '0;
                exp_ctl = CTL_IMM_TO_REG;
                exp_imm = w[23:8];
            end
            OP_LFUN_RC: begin
                exp_we  = reg_mask_t'(1) << b;
                exp_oe  = bus_bit(b, BUS_A);
                exp_alu = ALU_LOGIC;
                exp_ctl = CTL_REG_IMM;
                exp_imm = w[31:16];
            end
            OP_STORE: begin
                exp_we  = '0;
                exp_dwe = 1'b1;
                exp_oe  = bus_bit(b, BUS_A) | bus_bit(c, BUS_B);
                exp_imm = w[31:16];
                exp_alu = (part == 0) ? ALU_ADD : ALU_ADD_HI;
                exp_ctl = (part == 0) ? CTL_STORE_LO : CTL_STORE_HI;
            end
            default: begin
                // Branches write the PC and test register b on bus C
                exp_we  = 16'h0001;
                exp_oe  = bus_bit(c, BUS_A) | bus_bit(b, BUS_C);
                exp_alu = (w[7:4] == 4'd11) ? ALU_BEZ : (w[7:4] == 4'd12) ? ALU_BNEZ : ALU_BGEZ;
                exp_ctl = CTL_REG_IMM;
                exp_imm = w[31:16];
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic [47:0] actual,
                               input logic [47:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs(input bit with_func);
        check_value("data_write_en", 48'(data_write_en), 48'(exp_dwe));
        check_value("alu_op", 48'(alu_op), 48'(exp_alu));
        check_value("ctl_out", 48'(ctl_out), 48'(exp_ctl));
        check_value("immediate", 48'(immediate), 48'(exp_imm));
        check_value("write_en", 48'(write_en), 48'(exp_we));
        check_value("output_en", output_en, exp_oe);
        if (with_func) begin
            check_value("alu_logic_func", 48'(alu_logic_func), 48'(exp_func));
        end
    endtask

    // Drives one byte on a falling edge and checks the registered result one cycle later
    task automatic run_cycle(input byte_t b, input bit with_func);
        data_in = b;
        @(negedge clk);
        check_outputs(with_func);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        opcode_t     op;
        logic [31:0] word;
        int          len;
        int          n_exec;
        seed     = 32'h945b;
        checks   = 0;
        errors   = 0;
        data_in  = '0;
        exp_dwe  = 1'b0;
        exp_alu  = '0;
        exp_ctl  = '0;
        exp_imm  = '0;
        exp_we   = '0;
        exp_oe   = '0;
        exp_func = '0;
        // Outputs stay clear in reset and up to the first rising edge after it
        @(negedge clk);
        check_outputs(1'b1);
        @(negedge reset);
        check_outputs(1'b1);
        for (int i = 0; i < NUM_INSNS; i++) begin
            op        = opcode_t'(4'(i % 16));
            word      = $random(seed);
            word[7:4] = op;
            len       = fetch_len(op);
            n_exec    = exec_len(op);
            for (int k = 0; k < len; k++) begin
                exp_dwe = 1'b0;
                exp_we  = 16'h0001;
                exp_oe  = bus_bit(4'd0, BUS_A);
                exp_alu = ALU_ADD;
                exp_ctl = CTL_FETCH;
                exp_imm = 16'd1;
                run_cycle(word[8*k +: 8], 1'b0);
            end
            // Decode clears only the write enables, the input byte is ignored
            exp_we  = '0;
            exp_dwe = 1'b0;
            run_cycle(byte_t'($random(seed)), 1'b0);
            for (int k = 0; k < n_exec; k++) begin
                expect_exec(word, k);
                run_cycle(byte_t'($random(seed)), 1'b1);
            end
        end
        $display("Checks run: %0d, value errors: %0d, assertion errors: %0d",
                 checks, errors, dut.chk.fail_count);
        if (errors == 0 && dut.chk.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Ends a run that never reaches the closing line
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the instruction stream did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* cpu_ctl.f */
hdl/cpu_ctl_pkg.sv
hdl/insn_fetch.sv
hdl/exec_sequencer.sv
hdl/ctl_word_gen.sv
hdl/cpu_ctl_top.sv
bench/tb_clock.sv
bench/cpu_ctl_chk.sv
bench/cpu_ctl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_ctl_tb
FILELIST  ?= cpu_ctl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
